/* logic/tcm_pkg.sv */
`default_nettype none

// Widths and target names shared by the memory subsystem
package tcm_pkg;

   // Data word width
   parameter int DATA_W = 32;

   // Byte lanes per data word
   parameter int NUM_LANES = 4;

   // Width of one byte lane
   parameter int LANE_W = DATA_W / NUM_LANES;

   // Byte address width of the peripheral window
   // Four bytes per word, four words in the block
   parameter int PERIPH_ADDR_W = 4;

   // Target selected by the region bit of the external address
   // Encoding follows the region bit itself
   typedef enum logic {
      TGT_TCM    = 1'b0,
      TGT_PERIPH = 1'b1
   } tcm_target_e;

endpackage : tcm_pkg

`default_nettype wire

/* logic/mem_port_if.sv */
`default_nettype none

// One request/response port between the fabric and a target
// Request is held until ready_nxt, read data follows one cycle later
interface mem_port_if #(
   parameter int ADDR_W = 12
);
   import tcm_pkg::*;

   // Request side, driven by the initiator
   logic                 en;
   logic [ADDR_W-1:0]    addr;
   logic [DATA_W-1:0]    wdata;
   // Non-zero lanes with en high mean write
   logic [NUM_LANES-1:0] bytesel;

   // Response side, driven by the target
   // Access completes at the end of the cycle where ready_nxt is high
   logic                 ready_nxt;
   logic [DATA_W-1:0]    rdata;

   // Fabric side
   modport initiator (
      output en, addr, wdata, bytesel,
      input  ready_nxt, rdata
   );

   // Memory or register block side
   modport target (
      input  en, addr, wdata, bytesel,
      output ready_nxt, rdata
   );

endinterface : mem_port_if

`default_nettype wire

/* logic/bytewrite_ram_32bits.sv */
`default_nettype none

// Single-port synchronous RAM with per-byte write enables
// Read data is registered every clock, one cycle of read latency
module bytewrite_ram_32bits #(
   parameter int SIZE   = 1024,
   parameter int ADDR_W = 10
) (
   input  wire                            clk,
   input  wire  [tcm_pkg::NUM_LANES-1:0] we,
   input  wire  [ADDR_W-1:0]             addr,
   input  wire  [tcm_pkg::DATA_W-1:0]    din,
   output logic [tcm_pkg::DATA_W-1:0]    dout
);
   import tcm_pkg::*;

   // Word storage
   logic [DATA_W-1:0] mem [0:SIZE-1];

   // Lane-wise write
   always_ff @(posedge clk) begin
      for (int l = 0; l < NUM_LANES; l++) begin
         if (we[l]) begin
            mem[addr][l*LANE_W +: LANE_W] <= din[l*LANE_W +: LANE_W];
         end
      end
   end

   // Registered read, old data on a write to the same word
   always_ff @(posedge clk) begin
      dout <= mem[addr];
   end

   // A write must land inside the array
   // The controller slices the byte address, so a depth/width mismatch shows here
   a_wr_in_range: assert property (
      @(posedge clk) (|we) |-> (addr < SIZE)
   ) else $error("RAM write to word %0d beyond depth %0d", addr, SIZE);

endmodule : bytewrite_ram_32bits

`default_nettype wire

/* logic/tcm_ctrl.sv */
`default_nettype none

// Controller for the tightly coupled RAM
// Writes and fast reads complete in the first cycle, slow reads in the second
module tcm_ctrl #(
   parameter int TCM_WORDS  = 1024,
   parameter int TCM_ADDR_W = 12
) (
   input  wire         clk,
   input  wire         rst_n,
   input  wire         fast_handshaking,
   mem_port_if.target  port
);
   import tcm_pkg::*;

   logic [NUM_LANES-1:0] we;
   logic                 write_access;
   // Slow read has spent its wait cycle
   logic                 rd_wait_q;

   // Byte lanes only count while the request is valid
   assign we           = port.bytesel & {NUM_LANES{port.en}};
   assign write_access = |we;

   // Word address drops the two byte offset bits
   bytewrite_ram_32bits #(
      .SIZE   (TCM_WORDS),
      .ADDR_W (TCM_ADDR_W - 2)
   ) u_mem (
      .clk  (clk),
      .we   (we),
      .addr (port.addr[TCM_ADDR_W-1:2]),
      .din  (port.wdata),
      .dout (port.rdata)
   );

   // Set after the first cycle of a slow read
   // Cleared on completion so a back-to-back read waits again
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_wait_q <= 1'b0;
      end else begin
         rd_wait_q <= port.en & ~write_access & ~port.ready_nxt;
      end
   end

   // Write: RAM takes the data at this edge
   // Fast read: requester samples the RAM output one cycle later
   // Slow read: ready only once the wait cycle has passed
   assign port.ready_nxt = port.en & (write_access | fast_handshaking | rd_wait_q);

   // The registered wait flag never outlives its request
   a_wait_needs_en: assert property (
      @(posedge clk) disable iff (!rst_n)
      rd_wait_q |-> port.en
   ) else $error("TCM read wait flag set without en");

endmodule : tcm_ctrl

`default_nettype wire

/* logic/periph_regs.sv */
`default_nettype none

// Peripheral register block
// Word 0 is a read-only ID, words 1 to 3 are byte-writable scratch registers
module periph_regs #(
   parameter logic [tcm_pkg::DATA_W-1:0] PERIPH_ID = 32'h5256_0001
) (
   input  wire         clk,
   input  wire         rst_n,
   mem_port_if.target  port
);
   import tcm_pkg::*;

   localparam int NUM_SCRATCH = 3;

   // Word index from the byte address
   logic [1:0]        idx;
   logic              wr_en;
   logic              rd_en;
   logic [DATA_W-1:0] scratch_q [1:NUM_SCRATCH];
   logic [DATA_W-1:0] rd_word;
   logic [DATA_W-1:0] rdata_q;

   assign idx   = port.addr[PERIPH_ADDR_W-1:2];
   assign wr_en = port.en & (|port.bytesel);
   assign rd_en = port.en & ~(|port.bytesel);

   // Registers never stall
   assign port.ready_nxt = port.en;

   // Scratch writes, lane by lane
   // Writes to the ID word fall through
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 1; i <= NUM_SCRATCH; i++) begin
            scratch_q[i] <= '0;
         end
      end else if (wr_en && idx != 2'd0) begin
         for (int l = 0; l < NUM_LANES; l++) begin
            if (port.bytesel[l]) begin
               scratch_q[idx][l*LANE_W +: LANE_W] <= port.wdata[l*LANE_W +: LANE_W];
            end
         end
      end
   end

   // Read mux
   always_comb begin
      case (idx)
         2'd0:    rd_word = PERIPH_ID;
         2'd1:    rd_word = scratch_q[1];
         2'd2:    rd_word = scratch_q[2];
         2'd3:    rd_word = scratch_q[3];
         default: rd_word = '0;
      endcase
   end

   // Capture at the completing edge
   // Valid in the following cycle, same as a fast TCM read
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rdata_q <= rd_word;
      end
   end

   assign port.rdata = rdata_q;

endmodule : periph_regs

`default_nettype wire

/* logic/bus_fabric.sv */
`default_nettype none

// Region decoder and response merger
// Region bit picks the target, no cycles added on the request path
module bus_fabric #(
   parameter int TCM_ADDR_W = 12
) (
   input  wire                            clk,
   input  wire                            rst_n,
   input  wire                            en,
   input  wire  [TCM_ADDR_W:0]            addr,
   input  wire  [tcm_pkg::DATA_W-1:0]    din,
   input  wire  [tcm_pkg::NUM_LANES-1:0] bytesel,
   output logic                           ready_nxt,
   output logic [tcm_pkg::DATA_W-1:0]    dout,
   mem_port_if.initiator                  tcm_port,
   mem_port_if.initiator                  periph_port
);
   import tcm_pkg::*;

   // Target of the current request
   tcm_target_e sel;
   // Target of the last completed read, steers dout
   tcm_target_e rd_tgt_q;
   logic        rd_done;

   // Top address bit is the region
   assign sel = tcm_target_e'(addr[TCM_ADDR_W]);

   // Only the selected target sees en
   assign tcm_port.en    = en & (sel == TGT_TCM);
   assign periph_port.en = en & (sel == TGT_PERIPH);

   // Payload goes to both, en decides who acts on it
   assign tcm_port.addr       = addr[TCM_ADDR_W-1:0];
   assign tcm_port.wdata      = din;
   assign tcm_port.bytesel    = bytesel;
   assign periph_port.addr    = addr[PERIPH_ADDR_W-1:0];
   assign periph_port.wdata   = din;
   assign periph_port.bytesel = bytesel;

   // Ready from the selected target, combinational
   assign ready_nxt = (sel == TGT_PERIPH) ? periph_port.ready_nxt : tcm_port.ready_nxt;

   // A read completes at this edge
   assign rd_done = en & ready_nxt & ~(|bytesel);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rd_tgt_q <= TGT_TCM;
      end else if (rd_done) begin
         rd_tgt_q <= sel;
      end
   end

   // Both targets present data one cycle after completion
   assign dout = (rd_tgt_q == TGT_PERIPH) ? periph_port.rdata : tcm_port.rdata;

   // Requester holds a pending request until ready_nxt
   property p_req_held;
      @(posedge clk) disable iff (!rst_n)
      (en && !ready_nxt) |=>
         (en && $stable(addr) && $stable(din) && $stable(bytesel));
   endproperty

   a_req_held: assert property (p_req_held)
      else $error("request withdrawn or changed before ready_nxt");

   // No target may complete an access nobody asked for
   a_ready_needs_en: assert property (
      @(posedge clk) disable iff (!rst_n)
      !en |-> !ready_nxt
   ) else $error("ready_nxt high while en is low");

endmodule : bus_fabric

`default_nettype wire

/* logic/tcm_subsys.sv */
`default_nettype none

// Local memory subsystem behind the core data port
// TCM below the region bit, peripheral registers above it
module tcm_subsys #(
   parameter int                         TCM_WORDS  = 1024,
   parameter int                         TCM_ADDR_W = 12,
   parameter logic [tcm_pkg::DATA_W-1:0] PERIPH_ID  = 32'h5256_0001
) (
   input  wire                            clk,
   input  wire                            rst_n,
   input  wire                            en,
   input  wire  [TCM_ADDR_W:0]            addr,
   input  wire  [tcm_pkg::DATA_W-1:0]    din,
   input  wire  [tcm_pkg::NUM_LANES-1:0] bytesel,
   input  wire                            fast_handshaking,
   output logic                           ready_nxt,
   output logic [tcm_pkg::DATA_W-1:0]    dout
);
   import tcm_pkg::*;

   // One port per target
   mem_port_if #(.ADDR_W(TCM_ADDR_W))    tcm_port ();
   mem_port_if #(.ADDR_W(PERIPH_ADDR_W)) periph_port ();

   // Decoder and merger
   bus_fabric #(
      .TCM_ADDR_W (TCM_ADDR_W)
   ) u_fabric (
      .clk         (clk),
      .rst_n       (rst_n),
      .en          (en),
      .addr        (addr),
      .din         (din),
      .bytesel     (bytesel),
      .ready_nxt   (ready_nxt),
      .dout        (dout),
      .tcm_port    (tcm_port.initiator),
      .periph_port (periph_port.initiator)
   );

   // RAM side, read wait depends on fast_handshaking
   tcm_ctrl #(
      .TCM_WORDS  (TCM_WORDS),
      .TCM_ADDR_W (TCM_ADDR_W)
   ) u_tcm (
      .clk              (clk),
      .rst_n            (rst_n),
      .fast_handshaking (fast_handshaking),
      .port             (tcm_port.target)
   );

   // Register side, always ready
   periph_regs #(
      .PERIPH_ID (PERIPH_ID)
   ) u_periph (
      .clk   (clk),
      .rst_n (rst_n),
      .port  (periph_port.target)
   );

endmodule : tcm_subsys

`default_nettype wire

/* test/tb_clk_gen.sv */
`default_nettype none

// Free-running testbench clock
// Starts low, first rising edge after half a period
module tb_clk_gen #(
   parameter int PERIOD = 4
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
   end

   // Half period high, half period low
   always #(PERIOD / 2) clk = ~clk;

endmodule : tb_clk_gen

`default_nettype wire

/* test/tb_tcm_subsys.sv */
`default_nettype none

// Testbench for the local memory subsystem
// Random accesses to both regions, checked against shadow copies of RAM and registers
module tb_tcm_subsys;

   localparam int          CLK_PERIOD = 4;
   localparam int          TCM_WORDS  = 1024;
   localparam int          TCM_ADDR_W = 12;
   localparam logic [31:0] PERIPH_ID  = 32'hC0DE_0A51;

   // Accesses per test
   localparam int N_RAND_WR    = 256;
   localparam int N_TIMING     = 16;
   localparam int N_PERIPH     = 24;
   localparam int N_ISO        = 8;
   localparam int N_MIX        = 1500;
   localparam int NUM_ACCESSES = 2 + 2 * TCM_WORDS + N_RAND_WR + 3 * N_TIMING
                                 + 6 + 2 * N_PERIPH + 4 * N_ISO + N_MIX;
   // Slow read plus an idle cycle stays under 4 cycles, slack covers reset
   localparam int WATCHDOG_CYCLES = 4 * NUM_ACCESSES + 100;

   logic                clk;
   logic                rst_n;
   logic                en;
   logic [TCM_ADDR_W:0] addr;
   logic [31:0]         din;
   logic [3:0]          bytesel;
   logic                fast_handshaking;
   logic                ready_nxt;
   logic [31:0]         dout;

   // Shadow stores
   logic [31:0] tcm_model [0:TCM_WORDS-1];
   logic [31:0] periph_model [0:3];

   logic [31:0] rng;
   int          errors;
   int          checks;

   tb_clk_gen #(.PERIOD(CLK_PERIOD)) u_clk_gen (.clk(clk));

   tcm_subsys #(
      .TCM_WORDS  (TCM_WORDS),
      .TCM_ADDR_W (TCM_ADDR_W),
      .PERIPH_ID  (PERIPH_ID)
   ) tcm_subsys_inst (
      .clk              (clk),
      .rst_n            (rst_n),
      .en               (en),
      .addr             (addr),
      .din              (din),
      .bytesel          (bytesel),
      .fast_handshaking (fast_handshaking),
      .ready_nxt        (ready_nxt),
      .dout             (dout)
   );

   // Watchdog
   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Simulation FAILED");
      $finish;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] rand_next();
      rng = xorshift32(rng);
      return rng;
   endfunction

   // Lanes with bytesel set take the new byte
   function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                               input logic [31:0] new_w,
                                               input logic [3:0]  bs);
      logic [31:0] m;
      m = old_w;
      for (int l = 0; l < 4; l++) begin
         if (bs[l]) m[l*8 +: 8] = new_w[l*8 +: 8];
      end
      return m;
   endfunction

   // Zero lanes would turn a write into a read
   function automatic logic [3:0] nonzero_lanes(input logic [3:0] b);
      return (b == 4'h0) ? 4'hF : b;
   endfunction

   function automatic logic [TCM_ADDR_W:0] tcm_addr(input int word, input logic [1:0] off);
      logic [TCM_ADDR_W:0] a;
      a = '0;
      a[TCM_ADDR_W-1:2] = word[TCM_ADDR_W-3:0];
      a[1:0] = off;
      return a;
   endfunction

   // Upper offset bits random, so word indices alias
   function automatic logic [TCM_ADDR_W:0] periph_addr(input logic [1:0]  idx,
                                                       input logic [31:0] r);
      logic [TCM_ADDR_W:0] a;
      a = {1'b1, r[TCM_ADDR_W-1:0]};
      a[3:2] = idx;
      return a;
   endfunction

   task automatic check_value(input string sig, input logic [31:0] got,
                              input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s got 0x%08h expected 0x%08h", $time, sig, got, exp);
      end
   endtask

   // Drop the request and check ready stays low
   task automatic idle(input int n);
      en      = 1'b0;
      bytesel = '0;
      repeat (n) begin
         #1;
         check_value("ready_nxt while idle", {31'd0, ready_nxt}, 32'd0);
         @(posedge clk);
         #1;
      end
   endtask

   // One request held until ready_nxt, entered 1 unit after a rising edge
   // Returns 1 unit after the completing edge, request still on the bus
   task automatic run_access(input logic [TCM_ADDR_W:0] a, input logic [31:0] d,
                             input logic [3:0] bs, input logic fast);
      logic                  is_periph;
      logic                  is_write;
      logic                  rdy;
      logic [1:0]            idx;
      logic [TCM_ADDR_W-3:0] word;
      logic [31:0]           exp_data;
      logic [31:0]           exp_cycles;
      logic [31:0]           cycles;

      is_periph = a[TCM_ADDR_W];
      is_write  = |bs;
      idx       = a[3:2];
      word      = a[TCM_ADDR_W-1:2];
      exp_data  = is_periph ? periph_model[idx] : tcm_model[word];
      // Only a slow TCM read spends a wait cycle
      exp_cycles = (!is_periph && !is_write && !fast) ? 32'd2 : 32'd1;

      en               = 1'b1;
      addr             = a;
      din              = d;
      bytesel          = bs;
      fast_handshaking = fast;
      cycles           = '0;
      rdy              = 1'b0;
      while (!rdy) begin
         // Mid-cycle, combinational ready has settled
         #1;
         cycles = cycles + 1;
         rdy    = ready_nxt;
         @(posedge clk);
         #1;
      end
      check_value("ready_nxt latency", cycles, exp_cycles);

      if (!is_write) begin
         check_value("dout", dout, exp_data);
      end else if (!is_periph) begin
         tcm_model[word] = merge_lanes(tcm_model[word], d, bs);
      end else if (idx != 2'd0) begin
         // ID word ignores writes
         periph_model[idx] = merge_lanes(periph_model[idx], d, bs);
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      $display("Test %-24s %0d errors", name, errors - errs_before);
   endtask

   initial begin
      logic [31:0]         r;
      logic [TCM_ADDR_W:0] a;
      int                  e0;

      rst_n            = 1'b0;
      en               = 1'b0;
      addr             = '0;
      din              = '0;
      bytesel          = '0;
      fast_handshaking = 1'b0;
      rng              = 32'h4f2e_5bd1;
      errors           = 0;
      checks           = 0;
      periph_model[0]  = PERIPH_ID;
      for (int i = 1; i < 4; i++) periph_model[i] = '0;

      repeat (5) @(posedge clk);
      #1;
      rst_n = 1'b1;

      // 1: quiet bus, then one write and read back
      e0 = errors;
      idle(4);
      run_access(tcm_addr(5, 2'd0), 32'hA5C3_0F17, 4'hF, 1'b1);
      run_access(tcm_addr(5, 2'd0), rand_next(), 4'h0, 1'b1);
      idle(1);
      report_test("reset_and_basic", e0);

      // 2: fill every word, scatter lane writes, read the whole range
      e0 = errors;
      for (int w = 0; w < TCM_WORDS; w++) begin
         run_access(tcm_addr(w, 2'd0), rand_next(), 4'hF, 1'b1);
      end
      for (int i = 0; i < N_RAND_WR; i++) begin
         r = rand_next();
         run_access(tcm_addr(rand_next() % TCM_WORDS, r[1:0]), rand_next(),
                    nonzero_lanes(r[7:4]), r[8]);
      end
      for (int w = 0; w < TCM_WORDS; w++) begin
         r = rand_next();
         run_access(tcm_addr(w, r[1:0]), rand_next(), 4'h0, r[2]);
      end
      idle(1);
      report_test("tcm_byte_lanes", e0);

      // 3: write, fast read, slow read on the same word
      e0 = errors;
      for (int i = 0; i < N_TIMING; i++) begin
         a = tcm_addr(rand_next() % TCM_WORDS, 2'd0);
         run_access(a, rand_next(), 4'hF, 1'b0);
         run_access(a, rand_next(), 4'h0, 1'b1);
         run_access(a, rand_next(), 4'h0, 1'b0);
      end
      idle(1);
      report_test("handshake_timing", e0);

      // 4: scratch reset values, ID read only, aliased scratch access
      e0 = errors;
      for (int i = 1; i < 4; i++) run_access(periph_addr(2'(i), rand_next()), 0, 4'h0, 1'b1);
      run_access(periph_addr(2'd0, rand_next()), rand_next(), 4'h0, 1'b1);
      run_access(periph_addr(2'd0, rand_next()), rand_next(), 4'hF, 1'b1);
      run_access(periph_addr(2'd0, rand_next()), rand_next(), 4'h0, 1'b0);
      for (int i = 0; i < N_PERIPH; i++) begin
         r = rand_next();
         run_access(periph_addr(r[1:0], rand_next()), rand_next(), nonzero_lanes(r[7:4]), 1'b1);
         run_access(periph_addr(r[1:0], rand_next()), rand_next(), 4'h0, r[8]);
      end
      idle(1);
      report_test("periph_regs", e0);

      // 5: same low offsets in both regions
      e0 = errors;
      for (int i = 0; i < N_ISO; i++) begin
         a = periph_addr(2'(1 + i % 3), rand_next());
         run_access(a, rand_next(), 4'hF, 1'b1);
         run_access({1'b0, a[TCM_ADDR_W-1:0]}, rand_next(), 4'h0, 1'b1);
         run_access({1'b0, a[TCM_ADDR_W-1:0]}, rand_next(), 4'hF, 1'b1);
         run_access(a, rand_next(), 4'h0, 1'b1);
      end
      idle(1);
      report_test("region_isolation", e0);

      // 6: back-to-back mix, an idle cycle now and then
      e0 = errors;
      for (int i = 0; i < N_MIX; i++) begin
         r = rand_next();
         if (r[4]) a = periph_addr(r[9:8], rand_next());
         else      a = tcm_addr(rand_next() % TCM_WORDS, r[11:10]);
         run_access(a, rand_next(), r[5] ? nonzero_lanes(r[15:12]) : 4'h0, r[6]);
         if (r[23:21] == 3'd0) idle(1);
      end
      idle(1);
      report_test("random_mix", e0);

      $display("Summary: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule : tb_tcm_subsys

`default_nettype wire

/* vlog.f */
logic/tcm_pkg.sv
logic/mem_port_if.sv
logic/bytewrite_ram_32bits.sv
logic/tcm_ctrl.sv
logic/periph_regs.sv
logic/bus_fabric.sv
logic/tcm_subsys.sv
test/tb_clk_gen.sv
test/tb_tcm_subsys.sv

/* Bender.yml */
package:
  name: tcm_subsys

sources:
  # Design, package and interface first
  - files:
      - logic/tcm_pkg.sv
      - logic/mem_port_if.sv
      - logic/bytewrite_ram_32bits.sv
      - logic/tcm_ctrl.sv
      - logic/periph_regs.sv
      - logic/bus_fabric.sv
      - logic/tcm_subsys.sv

  # Testbench
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_tcm_subsys.sv
